/* reg_subsys_top.f */
src/reg_pkg.sv
src/reg_native_if.sv
src/reg_cmd_queue.sv
src/reg_access_ctrl.sv
src/reg_mem.sv
src/reg_subsys_top.sv
verification/tb_reg_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f reg_subsys_top.f --top-module tb_reg_subsys -o sim_tb

# The simulator exits non-zero on $fatal, so keep going and let the log decide
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failures"

/* src/reg_access_ctrl.sv */
`timescale 1ns/1ps

module reg_access_ctrl import reg_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  reg_cmd_t               head,
    input  logic                   head_vld,
    output logic                   pop,
    reg_native_if.ctrl             bus,
    output logic                   rsp_vld,
    input  logic                   rsp_rdy,
    output logic [DATA_WIDTH-1:0]  rsp_rdata,
    output reg_status_e            rsp_status
);

    ctrl_state_e                state;
    ctrl_state_e                state_nxt;
    reg_cmd_t                   cmd_q;
    logic [TO_CNT_WIDTH-1:0]    wait_cnt;
    logic                       take_cmd;
    logic                       ack_hit;
    logic                       timed_out;

    // Decisions shared by the state and payload registers
    assign take_cmd  = (state == IDLE) && head_vld;
    assign ack_hit   = (state == WAIT_ACK) && bus.ack_vld;
    assign timed_out = (state == WAIT_ACK) && !bus.ack_vld &&
                       (wait_cnt == TO_CNT_WIDTH'(ACK_TIMEOUT - 1));

    assign pop = take_cmd;

    // Native request, held for as long as the FSM sits in REQ
    assign bus.req_vld = (state == REQ);
    assign bus.wr_en   = (state == REQ) && (cmd_q.op == OP_WRITE);
    assign bus.rd_en   = (state == REQ) && (cmd_q.op == OP_READ);
    assign bus.addr    = cmd_q.addr;
    assign bus.wr_data = cmd_q.wdata;
    assign bus.ack_rdy = (state == WAIT_ACK);

    assign rsp_vld = (state == RESP);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (head_vld)
                    state_nxt = REQ;
            end
            REQ: begin
                if (bus.req_rdy)
                    state_nxt = WAIT_ACK;
            end
            WAIT_ACK: begin
                if (ack_hit || timed_out)
                    state_nxt = RESP;
            end
            RESP: begin
                // Stay here under back-pressure so no new command is popped
                if (rsp_rdy)
                    state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Timeout counter, starts over every time WAIT_ACK is entered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wait_cnt <= '0;
        else if (state == WAIT_ACK)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    // Command latch
    always_ff @(posedge clk) begin
        if (take_cmd)
            cmd_q <= head;
    end

    // Response payload, held stable through RESP
    always_ff @(posedge clk) begin
        if (ack_hit) begin
            rsp_status <= ST_OK;
            if (cmd_q.op == OP_READ)
                rsp_rdata <= bus.rd_data;
            else
                rsp_rdata <= '0;
        end else if (timed_out) begin
            rsp_status <= ST_TIMEOUT;
            rsp_rdata  <= '0;
        end
    end

endmodule

/* src/reg_cmd_queue.sv */
`timescale 1ns/1ps

module reg_cmd_queue import reg_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_vld,
    output logic     push_rdy,
    input  reg_cmd_t push_cmd,
    output reg_cmd_t head,
    output logic     head_vld,
    input  logic     pop
);

    reg_cmd_t                   entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
    logic [QUEUE_CNT_WIDTH-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign push_rdy = (count != QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
    assign head_vld = (count != '0);
    assign head     = entries[rd_ptr];

    assign do_push  = push_vld && push_rdy;
    assign do_pop   = pop && head_vld;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_cmd;
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/reg_mem.sv */
`timescale 1ns/1ps

module reg_mem import reg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    reg_native_if.mem bus
);

    logic [DATA_WIDTH-1:0]      mem [MEM_ENTRIES];

    // Request captured on the req_vld/req_rdy handshake
    logic                       smp_vld;
    logic                       smp_wr;
    logic                       smp_rd;
    logic [ADDR_WIDTH-1:0]      smp_addr;
    logic [DATA_WIDTH-1:0]      smp_wdata;
    logic                       smp_mapped;
    logic [MEM_ADDR_WIDTH-1:0]  smp_index;

    // Array access done, acknowledge follows
    logic                       acc_vld;

    assign smp_mapped = (smp_addr[ADDR_WIDTH-1:MEM_ADDR_WIDTH] == '0);
    assign smp_index  = smp_addr[MEM_ADDR_WIDTH-1:0];

    // One-cycle req_rdy pulse per request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bus.req_rdy <= 1'b0;
        else
            bus.req_rdy <= bus.req_vld && !bus.req_rdy;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            smp_vld <= 1'b0;
        else
            smp_vld <= bus.req_vld && bus.req_rdy;
    end

    // Request fields are registered on every cycle
    always_ff @(posedge clk) begin
        smp_wr    <= bus.wr_en;
        smp_rd    <= bus.rd_en;
        smp_addr  <= bus.addr;
        smp_wdata <= bus.wr_data;
    end

    // Unmapped requests never touch the array
    always_ff @(posedge clk) begin
        if (smp_vld && smp_mapped) begin
            if (smp_wr)
                mem[smp_index] <= smp_wdata;
            if (smp_rd)
                bus.rd_data <= mem[smp_index];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            acc_vld <= 1'b0;
        else
            acc_vld <= smp_vld && smp_mapped && (smp_wr || smp_rd);
    end

    // ack_vld stays up until the controller takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bus.ack_vld <= 1'b0;
        else if (acc_vld)
            bus.ack_vld <= 1'b1;
        else if (bus.ack_rdy)
            bus.ack_vld <= 1'b0;
    end

endmodule

/* src/reg_native_if.sv */
`timescale 1ns/1ps

interface reg_native_if import reg_pkg::*; ();

    // Request channel
    logic                   req_vld;
    logic                   req_rdy;
    logic                   wr_en;
    logic                   rd_en;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [DATA_WIDTH-1:0]  wr_data;

    // Acknowledge channel, rd_data is valid with ack_vld on reads
    logic [DATA_WIDTH-1:0]  rd_data;
    logic                   ack_vld;
    logic                   ack_rdy;

    modport ctrl (
        output req_vld, wr_en, rd_en, addr, wr_data, ack_rdy,
        input  req_rdy, rd_data, ack_vld
    );

    modport mem (
        input  req_vld, wr_en, rd_en, addr, wr_data, ack_rdy,
        output req_rdy, rd_data, ack_vld
    );

endinterface

/* src/reg_pkg.sv */
package reg_pkg;

    // Data path and address widths
    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 8;

    // The memory decodes only the low address bits
    localparam int MEM_ADDR_WIDTH = 6;
    localparam int MEM_ENTRIES    = 1 << MEM_ADDR_WIDTH;

    // Command queue sizing
    localparam int QUEUE_DEPTH     = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

    // Cycles to wait for ack_vld once req_rdy has been seen
    localparam int ACK_TIMEOUT    = 16;
    localparam int TO_CNT_WIDTH   = $clog2(ACK_TIMEOUT);

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } reg_op_e;

    typedef enum logic {
        ST_OK      = 1'b0,
        ST_TIMEOUT = 1'b1
    } reg_status_e;

    // One host command as it travels through the queue
    typedef struct packed {
        reg_op_e                op;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [DATA_WIDTH-1:0]  wdata;
    } reg_cmd_t;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REQ      = 2'd1,
        WAIT_ACK = 2'd2,
        RESP     = 2'd3
    } ctrl_state_e;

endpackage

/* src/reg_subsys_top.sv */
`timescale 1ns/1ps

module reg_subsys_top import reg_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Host command channel
    input  logic                   cmd_vld,
    output logic                   cmd_rdy,
    input  reg_op_e                cmd_op,
    input  logic [ADDR_WIDTH-1:0]  cmd_addr,
    input  logic [DATA_WIDTH-1:0]  cmd_wdata,

    // Host response channel
    output logic                   rsp_vld,
    input  logic                   rsp_rdy,
    output logic [DATA_WIDTH-1:0]  rsp_rdata,
    output reg_status_e            rsp_status
);

    reg_cmd_t host_cmd;
    reg_cmd_t head;
    logic     head_vld;
    logic     pop;

    assign host_cmd = '{op: cmd_op, addr: cmd_addr, wdata: cmd_wdata};

    reg_native_if u_bus ();

    reg_cmd_queue u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push_vld (cmd_vld),
        .push_rdy (cmd_rdy),
        .push_cmd (host_cmd),
        .head     (head),
        .head_vld (head_vld),
        .pop      (pop)
    );

    reg_access_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .head_vld   (head_vld),
        .pop        (pop),
        .bus        (u_bus.ctrl),
        .rsp_vld    (rsp_vld),
        .rsp_rdy    (rsp_rdy),
        .rsp_rdata  (rsp_rdata),
        .rsp_status (rsp_status)
    );

    reg_mem u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (u_bus.mem)
    );

endmodule

/* verification/tb_reg_subsys.sv */
`timescale 1ns/1ps

module tb_reg_subsys import reg_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int RANDOM_OPS     = 200;
    localparam int CMD_WAIT_MAX   = 200;
    localparam int RSP_WAIT_MAX   = 100;
    localparam int DRAIN_WAIT_MAX = 5000;

    typedef enum logic [1:0] {
        RDY_HIGH,
        RDY_LOW,
        RDY_RANDOM
    } rdy_mode_e;

    logic                   clk;
    logic                   rst_n;
    logic                   cmd_vld;
    logic                   cmd_rdy;
    reg_op_e                cmd_op;
    logic [ADDR_WIDTH-1:0]  cmd_addr;
    logic [DATA_WIDTH-1:0]  cmd_wdata;
    logic                   rsp_vld;
    logic                   rsp_rdy;
    logic [DATA_WIDTH-1:0]  rsp_rdata;
    reg_status_e            rsp_status;

    // Reference memory, one word for every command address
    logic [DATA_WIDTH-1:0]  model_mem [256];
    logic                   model_written [256];

    // Expected responses in command order
    logic [DATA_WIDTH-1:0]  exp_data_q [$];
    reg_status_e            exp_status_q [$];

    logic [15:0]            cmd_lfsr;
    logic [15:0]            rdy_lfsr;
    rdy_mode_e              rdy_mode;

    reg_subsys_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_vld    (cmd_vld),
        .cmd_rdy    (cmd_rdy),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .rsp_vld    (rsp_vld),
        .rsp_rdy    (rsp_rdy),
        .rsp_rdata  (rsp_rdata),
        .rsp_status (rsp_status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step for every bit taken
    function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
        return v;
    endfunction

    // Expected response of one command, updates the model on mapped writes
    function automatic void ref_access(
        input  reg_op_e               op,
        input  logic [ADDR_WIDTH-1:0] addr,
        input  logic [DATA_WIDTH-1:0] wdata,
        output logic [DATA_WIDTH-1:0] exp_data,
        output reg_status_e           exp_status
    );
        if (int'(addr) >= MEM_ENTRIES) begin
            exp_data   = '0;
            exp_status = ST_TIMEOUT;
        end else if (op == OP_WRITE) begin
            model_mem[addr]     = wdata;
            model_written[addr] = 1'b1;
            exp_data            = '0;
            exp_status          = ST_OK;
        end else begin
            exp_data   = model_mem[addr];
            exp_status = ST_OK;
        end
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] got);
        if (got !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input reg_status_e exp,
                                input reg_status_e got);
        if (got !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, got);
            abort_run();
        end
    endtask

    // Entered and left at DRIVE_DELAY after a rising edge
    task automatic send_cmd(input reg_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata);
        int                    waited;
        logic [DATA_WIDTH-1:0] exp_data;
        reg_status_e           exp_status;
        waited    = 0;
        cmd_vld   = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        @(negedge clk);
        while (!cmd_rdy && waited < CMD_WAIT_MAX) begin
            waited++;
            @(negedge clk);
        end
        if (!cmd_rdy) begin
            $display("cmd_rdy stayed low, command to address 0x%h was never accepted", addr);
            abort_run();
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
            cmd_vld = 1'b0;
            ref_access(op, addr, wdata, exp_data, exp_status);
            exp_data_q.push_back(exp_data);
            exp_status_q.push_back(exp_status);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 && waited < DRAIN_WAIT_MAX) begin
            waited++;
            @(posedge clk);
        end
        if (exp_data_q.size() != 0) begin
            $display("Responses still outstanding after %0d cycles", waited);
            abort_run();
        end else begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Mode changes mid-cycle so the rsp_rdy driver sees it on the next edge
    task automatic set_rdy_mode(input rdy_mode_e mode);
        @(negedge clk);
        rdy_mode = mode;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // rsp_rdy driver, high about three cycles out of four in random mode
    initial begin
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            case (rdy_mode)
                RDY_HIGH: rsp_rdy = 1'b1;
                RDY_LOW:  rsp_rdy = 1'b0;
                default:  rsp_rdy = (take_bits(rdy_lfsr, 2) != 32'd0);
            endcase
        end
    end

    // Compare process, one expected entry per response handshake
    initial begin
        int                    stall;
        logic [DATA_WIDTH-1:0] exp_data;
        reg_status_e           exp_status;
        stall = 0;
        forever begin
            @(negedge clk);
            if (rsp_vld && rsp_rdy) begin
                stall = 0;
                if (exp_data_q.size() == 0) begin
                    $display("A response arrived with no command outstanding");
                    abort_run();
                end else begin
                    exp_data   = exp_data_q.pop_front();
                    exp_status = exp_status_q.pop_front();
                    check_data("rsp_rdata", exp_data, rsp_rdata);
                    check_status("rsp_status", exp_status, rsp_status);
                end
            end else if (!rsp_vld && exp_data_q.size() != 0) begin
                stall++;
                if (stall > RSP_WAIT_MAX) begin
                    $display("rsp_vld stayed low while commands were outstanding");
                    abort_run();
                end
            end else begin
                stall = 0;
            end
        end
    end

    initial begin
        reg_op_e               op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        int                    waited;

        rst_n     = 1'b0;
        cmd_vld   = 1'b0;
        cmd_op    = OP_READ;
        cmd_addr  = '0;
        cmd_wdata = '0;
        rsp_rdy   = 1'b0;
        rdy_mode  = RDY_HIGH;
        cmd_lfsr  = 16'd35;
        rdy_lfsr  = 16'd35;
        foreach (model_mem[i]) begin
            model_mem[i]     = '0;
            model_written[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        // Idle after reset
        @(negedge clk);
        check_flag("rsp_vld", 1'b0, rsp_vld);
        check_flag("cmd_rdy", 1'b1, cmd_rdy);
        @(posedge clk);
        #DRIVE_DELAY;

        send_cmd(OP_WRITE, 8'h05, 32'hA5A5_0F0F);
        send_cmd(OP_READ, 8'h05, '0);
        wait_drain();

        // Random mapped traffic with random response back-pressure
        set_rdy_mode(RDY_RANDOM);
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op   = (take_bits(cmd_lfsr, 1) == 32'd1) ? OP_WRITE : OP_READ;
            addr = ADDR_WIDTH'(take_bits(cmd_lfsr, MEM_ADDR_WIDTH));
            data = take_bits(cmd_lfsr, DATA_WIDTH);
            // A word is written before it is ever read
            if (!model_written[addr])
                op = OP_WRITE;
            send_cmd(op, addr, data);
        end
        wait_drain();
        set_rdy_mode(RDY_HIGH);

        // Unmapped addresses alias word 7 but must leave it alone
        send_cmd(OP_WRITE, 8'h07, 32'h1234_5678);
        send_cmd(OP_WRITE, 8'h47, 32'hDEAD_BEEF);
        send_cmd(OP_READ, 8'hC7, '0);
        send_cmd(OP_READ, 8'h07, '0);
        wait_drain();

        // One command executing and QUEUE_DEPTH waiting fill the subsystem
        set_rdy_mode(RDY_LOW);
        send_cmd(OP_WRITE, 8'h10, 32'h0000_1111);
        send_cmd(OP_WRITE, 8'h11, 32'h0000_2222);
        send_cmd(OP_READ, 8'h10, '0);
        send_cmd(OP_WRITE, 8'h90, 32'hFFFF_FFFF);
        send_cmd(OP_READ, 8'h11, '0);
        waited = 0;
        @(negedge clk);
        while (cmd_rdy && waited < CMD_WAIT_MAX) begin
            waited++;
            @(negedge clk);
        end
        if (cmd_rdy) begin
            $display("cmd_rdy never dropped while responses were held back");
            abort_run();
        end else begin
            repeat (10) @(negedge clk);
            check_flag("cmd_rdy", 1'b0, cmd_rdy);
            check_flag("rsp_vld", 1'b1, rsp_vld);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        set_rdy_mode(RDY_HIGH);
        wait_drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule
